// ==== burst/tmu_burst.sv ====
// --------------------------------------
// burst assembler and single-beat FML
// write master
// --------------------------------------
`timescale 1ns/1ps

module tmu_burst #(
	parameter int fml_depth = 26
) (
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic flush_i,
	output logic busy_o,

	input  logic pipe_stb_i,
	output logic pipe_ack_o,
	input  logic [tmu_pkg::color_width-1:0] color_i,
	input  logic [fml_depth-2:0] dadr_i,
	input  logic keep_i,

	output logic [fml_depth-1:0] fmlw_adr_o,
	output logic fmlw_stb_o,
	output logic [tmu_pkg::fml_sel_width-1:0] fmlw_sel_o,
	output logic [tmu_pkg::fml_word_width-1:0] fmlw_do_o,
	input  logic fmlw_ack_i
);

	localparam int lane_bits = $clog2(tmu_pkg::lanes_per_word);
	localparam int byte_bits = $clog2(tmu_pkg::fml_sel_width);
	localparam int word_bits = fml_depth - 1 - lane_bits;
	localparam int sel_per_lane = tmu_pkg::fml_sel_width / tmu_pkg::lanes_per_word;

	logic [word_bits-1:0] in_word;
	logic [lane_bits-1:0] lane_pos;

	// open word being assembled
	logic [word_bits-1:0] open_adr;
	logic [tmu_pkg::fml_sel_width-1:0] open_sel;
	logic [tmu_pkg::fml_word_width-1:0] open_data;

	// write stage, drives the FML bus directly
	logic w_stb;
	logic [word_bits-1:0] w_adr;
	logic [tmu_pkg::fml_sel_width-1:0] w_sel;
	logic [tmu_pkg::fml_word_width-1:0] w_data;

	logic new_word;
	logic need_write;
	logic w_free;
	logic accept;
	logic flush_load;
	logic w_load;
	logic [tmu_pkg::fml_sel_width-1:0] pix_sel;
	logic [tmu_pkg::fml_sel_width-1:0] next_sel;
	logic [tmu_pkg::fml_word_width-1:0] next_data;

	assign in_word = dadr_i[fml_depth-2:lane_bits];
	// lane 0 sits in the top 16 bits of the word
	assign lane_pos = lane_bits'(tmu_pkg::lanes_per_word - 1) - dadr_i[lane_bits-1:0];

	assign new_word = (in_word != open_adr);
	assign need_write = new_word && (open_sel != '0); // an empty word is simply dropped
	assign w_free = !w_stb || fmlw_ack_i;

	assign pipe_ack_o = !flush_i && (!need_write || w_free);
	assign accept = pipe_stb_i && pipe_ack_o;

	// the sequencer only flushes once the write stage has drained
	assign flush_load = flush_i && (open_sel != '0);
	assign w_load = (accept && need_write) || flush_load;

	always_comb begin
		pix_sel = '0;
		next_data = open_data;
		if (keep_i) begin
			pix_sel[lane_pos*sel_per_lane +: sel_per_lane] = '1;
			next_data[lane_pos*tmu_pkg::color_width +: tmu_pkg::color_width] = color_i;
		end
		next_sel = (new_word ? '0 : open_sel) | pix_sel; // a keyed pixel still opens its word
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			open_sel <= '0;
			w_stb <= 1'b0;
		end else begin
			if (accept)
				open_sel <= next_sel;
			else if (flush_load)
				open_sel <= '0;

			if (w_load)
				w_stb <= 1'b1;
			else if (fmlw_ack_i)
				w_stb <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			open_adr <= in_word;
			open_data <= next_data;
		end
		if (w_load) begin
			w_adr <= open_adr;
			w_sel <= open_sel;
			w_data <= open_data;
		end
	end

	assign fmlw_stb_o = w_stb;
	assign fmlw_adr_o = {w_adr, {byte_bits{1'b0}}};
	assign fmlw_sel_o = w_sel;
	assign fmlw_do_o = w_data;

	assign busy_o = w_stb; // a partly filled open word waits for the flush

	a_sel_nonzero: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlw_stb_o |-> fmlw_sel_o != '0);

endmodule

// ==== common/tmu_pkg.sv ====
// --------------------------------------
// shared widths, csr register indices and
// the run/flush sequencer state type
// --------------------------------------

package tmu_pkg;

	// RGB565 pixel layout
	localparam int color_width = 16;
	localparam int red_width = 5;
	localparam int green_width = 6;
	localparam int blue_width = 5;

	localparam int brightness_width = 6; // brightness 0..63, 63 leaves colors unchanged

	// one FML write word carries four pixels
	localparam int lanes_per_word = 4;
	localparam int fml_word_width = 64;
	localparam int fml_sel_width = 8;

	// csr word indices (byte offsets 00, 0C and 10)
	localparam int reg_ctrl = 0;
	localparam int reg_brightness = 3;
	localparam int reg_chroma_key = 4;

	localparam int ctrl_start_bit = 0;
	localparam int ctrl_chroma_en_bit = 1;

	typedef enum logic [1:0] {
		idle,
		wait_process,
		flush,
		wait_flush
	} run_state_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the tmu_pixel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 \
	--top-module tmu_pixel_tb -f tmu_pixel.f \
	--Mdir obj_dir -o tmu_pixel_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tmu_pixel_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION PASSED" <<< "$output"; then
	exit 0
fi
exit 1

// ==== sim/fml_write_model.sv ====
// --------------------------------------
// FML write slave with random ack delay
// and a per-lane log of every write
// --------------------------------------
`timescale 1ns/1ps

module fml_write_model #(
	parameter int fml_depth = 26,
	parameter int log_pixels = 1024
) (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic [fml_depth-1:0] fmlw_adr_i,
	input  logic fmlw_stb_i,
	input  logic [tmu_pkg::fml_sel_width-1:0] fmlw_sel_i,
	input  logic [tmu_pkg::fml_word_width-1:0] fmlw_do_i,
	output logic fmlw_ack_o
);

	localparam int log_words = log_pixels / tmu_pkg::lanes_per_word;
	localparam int byte_bits = $clog2(tmu_pkg::fml_sel_width);

	integer seed = 11;
	int delay;
	int wait_cnt;
	logic pending; // a write has been seen and its ack is scheduled

	// color and write count per pixel address, write count and select per word
	logic [tmu_pkg::color_width-1:0] lane_data [log_pixels];
	int lane_writes [log_pixels];
	int word_writes [log_words];
	logic [tmu_pkg::fml_sel_width-1:0] word_sel [log_words];

	task automatic record_write();
		int word;
		int pix;
		int l;
		word = int'(fmlw_adr_i >> byte_bits) % log_words;
		word_writes[word]++;
		word_sel[word] = fmlw_sel_i;
		for (l = 0; l < tmu_pkg::lanes_per_word; l++) begin
			pix = word * tmu_pkg::lanes_per_word + l;
			// lane 0 is the top 16 bits and select bits 7:6
			if (fmlw_sel_i[(3 - l) * 2 +: 2] != 2'b00) begin
				lane_writes[pix]++;
				lane_data[pix] = fmlw_do_i[(3 - l) * tmu_pkg::color_width +: tmu_pkg::color_width];
			end
		end
	endtask

	always @(posedge sys_clk) begin
		if (sys_rst) begin
			fmlw_ack_o <= 1'b0;
			pending <= 1'b0;
			wait_cnt <= 0;
		end else if (fmlw_ack_o) begin
			record_write(); // the write completes on this edge
			fmlw_ack_o <= 1'b0;
			pending <= 1'b0;
		end else if (fmlw_stb_i && !pending) begin
			delay = $random(seed) & 3;
			pending <= 1'b1;
			wait_cnt <= delay;
			fmlw_ack_o <= (delay == 0);
		end else if (pending && wait_cnt > 0) begin
			wait_cnt <= wait_cnt - 1;
			fmlw_ack_o <= (wait_cnt == 1);
		end
	end

endmodule

// ==== sim/tmu_pixel_tb.sv ====
// --------------------------------------
// testbench: csr and pixel stimulus, FML
// write model, watchdog and checks
// --------------------------------------
`timescale 1ns/1ps

module tmu_pixel_tb;

	localparam int fml_depth = 26;
	localparam logic [3:0] csr_addr = 4'h2;
	localparam int total_pixels = 63; // 8 + 4 + 8 + 3 + 40 over all runs

	logic sys_clk = 1'b0;
	logic sys_rst;
	logic [13:0] csr_a;
	logic csr_we;
	logic [31:0] csr_di;
	logic [31:0] csr_do;
	logic irq;
	logic pipe_stb;
	logic pipe_ack;
	logic [tmu_pkg::color_width-1:0] color;
	logic [fml_depth-2:0] dadr;
	logic last;
	logic [fml_depth-1:0] fmlw_adr;
	logic fmlw_stb;
	logic [tmu_pkg::fml_sel_width-1:0] fmlw_sel;
	logic [tmu_pkg::fml_word_width-1:0] fmlw_do;
	logic fmlw_ack;

	integer seed = 11;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errors_at_start;
	int irq_count = 0;
	bit run_active = 1'b0; // set from the start write until irq is seen
	string test_name;
	logic [tmu_pkg::color_width-1:0] px_color [$];
	int px_adr [$];
	logic [31:0] rd;

	always #50 sys_clk = ~sys_clk;

	tmu_pixel #(
		.fml_depth(fml_depth),
		.csr_addr(csr_addr)
	) tmu_pixel_i (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a_i(csr_a),
		.csr_we_i(csr_we),
		.csr_di_i(csr_di),
		.csr_do_o(csr_do),
		.irq_o(irq),
		.pipe_stb_i(pipe_stb),
		.pipe_ack_o(pipe_ack),
		.color_i(color),
		.dadr_i(dadr),
		.last_i(last),
		.fmlw_adr_o(fmlw_adr),
		.fmlw_stb_o(fmlw_stb),
		.fmlw_sel_o(fmlw_sel),
		.fmlw_do_o(fmlw_do),
		.fmlw_ack_i(fmlw_ack)
	);

	fml_write_model #(
		.fml_depth(fml_depth)
	) fml_model_i (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.fmlw_adr_i(fmlw_adr),
		.fmlw_stb_i(fmlw_stb),
		.fmlw_sel_i(fmlw_sel),
		.fmlw_do_i(fmlw_do),
		.fmlw_ack_o(fmlw_ack)
	);

	always @(negedge sys_clk) begin
		if (irq)
			irq_count++;
	end

	a_fml_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlw_stb && !fmlw_ack |=> fmlw_stb && $stable({fmlw_adr, fmlw_sel, fmlw_do}))
		else begin
			$display("FML write changed or dropped before its ack at %0t", $time);
			errors++;
		end

	a_fml_aligned: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlw_stb |-> fmlw_adr[2:0] == 3'b000)
		else begin
			$display("FML write address not aligned to a 64-bit word at %0t", $time);
			errors++;
		end

	// the decay stage must hold its pixel until the burst assembler takes it
	a_pipe_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		tmu_pixel_i.decay_stb && !tmu_pixel_i.decay_ack |=> tmu_pixel_i.decay_stb
			&& $stable({tmu_pixel_i.decay_color, tmu_pixel_i.decay_dadr,
			tmu_pixel_i.decay_keep}))
		else begin
			$display("decay output changed or dropped before it was acked at %0t", $time);
			errors++;
		end

	a_irq_in_run: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq |-> run_active)
		else begin
			$display("interrupt raised while no run was open at %0t", $time);
			errors++;
		end

	// expected color: each channel times (brightness + 1) over 64, rounded down
	function automatic logic [15:0] dim_color(input logic [15:0] c, input int bright);
		int r;
		int g;
		int b;
		r = int'(c[tmu_pkg::color_width-1 -: tmu_pkg::red_width]) * (bright + 1) / 64;
		g = int'(c[tmu_pkg::blue_width +: tmu_pkg::green_width]) * (bright + 1) / 64;
		b = int'(c[tmu_pkg::blue_width-1:0]) * (bright + 1) / 64;
		return {r[4:0], g[5:0], b[4:0]};
	endfunction

	task check_value(input string what, input int expected, input int actual);
		assert (expected == actual) else begin
			$display("mismatch %s %s: expected %0h actual %0h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
		px_color.delete();
		px_adr.delete();
	endtask

	task finish_test();
		tests_run++;
		if (errors != errors_at_start)
			tests_failed++;
		$display("test %s: %s", test_name, (errors == errors_at_start) ? "ok" : "failed");
	endtask

	task csr_write(input int idx, input logic [31:0] data);
		csr_a = {csr_addr, 10'(idx)};
		csr_we = 1'b1;
		csr_di = data;
		@(posedge sys_clk);
		#1;
		csr_we = 1'b0;
	endtask

	task csr_read(input int idx, output logic [31:0] data);
		csr_a = {csr_addr, 10'(idx)};
		@(posedge sys_clk);
		@(negedge sys_clk); // csr_do is one cycle behind the address
		data = csr_do;
		@(posedge sys_clk);
		#1;
	endtask

	task add_pixel(input int adr, input logic [15:0] c);
		px_adr.push_back(adr);
		px_color.push_back(c);
	endtask

	task add_random(input int base, input int count);
		int i;
		for (i = 0; i < count; i++)
			add_pixel(base + i, 16'($random(seed)));
	endtask

	// opens a run, streams the queued pixels and waits for the interrupt
	task send_run(input bit key_en);
		int i;
		run_active = 1'b1;
		irq_count = 0;
		csr_write(tmu_pkg::reg_ctrl, {30'd0, key_en, 1'b1});
		for (i = 0; i < px_color.size(); i++) begin
			pipe_stb = 1'b1;
			color = px_color[i];
			dadr = (fml_depth-1)'(px_adr[i]);
			last = (i == px_color.size() - 1);
			do @(negedge sys_clk); while (!pipe_ack);
			@(posedge sys_clk);
			#1;
		end
		pipe_stb = 1'b0;
		last = 1'b0;
		do @(negedge sys_clk); while (!irq);
		@(posedge sys_clk);
		#1;
		run_active = 1'b0;
		repeat (4) @(posedge sys_clk);
		#1;
		check_value("irq pulses", 1, irq_count);
	endtask

	task check_pixels(input int bright, input bit key_en, input logic [15:0] key);
		int i;
		int p;
		for (i = 0; i < px_color.size(); i++) begin
			p = px_adr[i];
			if (key_en && px_color[i] == key) begin
				check_value($sformatf("writes of keyed pixel %0d", p), 0, fml_model_i.lane_writes[p]);
			end else begin
				check_value($sformatf("writes of pixel %0d", p), 1, fml_model_i.lane_writes[p]);
				check_value($sformatf("color of pixel %0d", p), dim_color(px_color[i], bright),
					fml_model_i.lane_data[p]);
			end
		end
	endtask

	initial begin
		int i;
		sys_rst = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		pipe_stb = 1'b0;
		color = '0;
		dadr = '0;
		last = 1'b0;
		repeat (8) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;

		begin_test("register_readback");
		csr_read(tmu_pkg::reg_ctrl, rd);
		check_value("busy after reset", 0, rd[tmu_pkg::ctrl_start_bit]);
		csr_write(tmu_pkg::reg_brightness, 32'h2a);
		csr_write(tmu_pkg::reg_chroma_key, 32'h1234);
		csr_read(tmu_pkg::reg_brightness, rd);
		check_value("brightness", 32'h2a, rd);
		csr_read(tmu_pkg::reg_chroma_key, rd);
		check_value("chroma key", 32'h1234, rd);
		finish_test();

		begin_test("full_brightness");
		csr_write(tmu_pkg::reg_brightness, 32'd63);
		add_random(0, 8); // words 0 and 1
		send_run(1'b0);
		check_value("writes of word 0", 1, fml_model_i.word_writes[0]);
		check_value("writes of word 1", 1, fml_model_i.word_writes[1]);
		check_value("select of word 0", 8'hff, fml_model_i.word_sel[0]);
		check_value("select of word 1", 8'hff, fml_model_i.word_sel[1]);
		check_pixels(63, 1'b0, 16'h0);
		finish_test();

		begin_test("brightness_scaling");
		csr_write(tmu_pkg::reg_brightness, 32'd31);
		add_random(32, 4);
		send_run(1'b0);
		check_pixels(31, 1'b0, 16'h0);
		finish_test();

		begin_test("chroma_key");
		csr_write(tmu_pkg::reg_brightness, 32'd63);
		csr_write(tmu_pkg::reg_chroma_key, 32'hf81f);
		for (i = 64; i < 68; i++)
			add_pixel(i, 16'hf81f); // word 16 holds only key pixels
		add_pixel(68, 16'hf81f);
		add_pixel(69, 16'h07e0);
		add_pixel(70, 16'hf81f);
		add_pixel(71, 16'h001f);
		send_run(1'b1);
		check_value("writes of keyed word", 0, fml_model_i.word_writes[16]);
		check_value("writes of mixed word", 1, fml_model_i.word_writes[17]);
		check_value("select of mixed word", 8'h33, fml_model_i.word_sel[17]);
		check_pixels(63, 1'b1, 16'hf81f);
		finish_test();

		begin_test("partial_flush");
		add_random(80, 3); // lanes 0 to 2 of word 20
		send_run(1'b0);
		check_value("writes of partial word", 1, fml_model_i.word_writes[20]);
		check_value("select of partial word", 8'hfc, fml_model_i.word_sel[20]);
		csr_read(tmu_pkg::reg_ctrl, rd);
		check_value("busy after run", 0, rd[tmu_pkg::ctrl_start_bit]);
		check_pixels(63, 1'b0, 16'h0);
		finish_test();

		begin_test("back_pressure");
		add_random(256, 40);
		send_run(1'b0);
		check_pixels(63, 1'b0, 16'h0);
		finish_test();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// watchdog sized from the pixel count of all runs
	initial begin
		repeat (total_pixels * 20 + 2000) @(posedge sys_clk);
		$display("timeout: the tests did not finish in time, test %s", test_name);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== source/tmu_ctlif.sv ====
// --------------------------------------
// csr register decode, start pulse, run
// and flush sequencer, completion interrupt
// --------------------------------------
`timescale 1ns/1ps

module tmu_ctlif #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic [13:0] csr_a_i,
	input  logic csr_we_i,
	input  logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,

	output logic irq_o,

	output logic run_o,
	output logic [tmu_pkg::brightness_width-1:0] brightness_o,
	output logic chroma_key_en_o,
	output logic [tmu_pkg::color_width-1:0] chroma_key_o,
	output logic flush_o,

	input  logic last_seen_i,
	input  logic decay_busy_i,
	input  logic burst_busy_i
);

	tmu_pkg::run_state_t state;
	tmu_pkg::run_state_t state_next;

	logic csr_selected;
	logic start;
	logic run_q;

	assign csr_selected = (csr_a_i[13:10] == csr_addr);
	assign start = csr_selected && csr_we_i
		&& (csr_a_i[9:0] == 10'(tmu_pkg::reg_ctrl))
		&& csr_di_i[tmu_pkg::ctrl_start_bit];

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			brightness_o <= '1; // full brightness out of reset
			chroma_key_en_o <= 1'b0;
			chroma_key_o <= '0;
		end else if (csr_selected && csr_we_i) begin
			case (csr_a_i[9:0])
				10'(tmu_pkg::reg_ctrl): chroma_key_en_o <= csr_di_i[tmu_pkg::ctrl_chroma_en_bit];
				10'(tmu_pkg::reg_brightness): brightness_o <= csr_di_i[tmu_pkg::brightness_width-1:0];
				10'(tmu_pkg::reg_chroma_key): chroma_key_o <= csr_di_i[tmu_pkg::color_width-1:0];
				default: ;
			endcase
		end
	end

	// readback lags the address by one cycle
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do_o <= '0;
		end else begin
			csr_do_o <= '0;
			if (csr_selected) begin
				case (csr_a_i[9:0])
					10'(tmu_pkg::reg_ctrl): begin
						csr_do_o[tmu_pkg::ctrl_start_bit] <= (state != tmu_pkg::idle);
						csr_do_o[tmu_pkg::ctrl_chroma_en_bit] <= chroma_key_en_o;
					end
					10'(tmu_pkg::reg_brightness): csr_do_o[tmu_pkg::brightness_width-1:0] <= brightness_o;
					10'(tmu_pkg::reg_chroma_key): csr_do_o[tmu_pkg::color_width-1:0] <= chroma_key_o;
					default: ;
				endcase
			end
		end
	end

	// run stays open until decay takes the pixel marked last
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			run_q <= 1'b0;
		end else if (start && state == tmu_pkg::idle) begin
			run_q <= 1'b1;
		end else if (last_seen_i) begin
			run_q <= 1'b0;
		end
	end

	assign run_o = run_q;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= tmu_pkg::idle;
			irq_o <= 1'b0;
		end else begin
			state <= state_next;
			irq_o <= (state == tmu_pkg::wait_flush) && !burst_busy_i;
		end
	end

	always_comb begin
		state_next = state;
		flush_o = 1'b0;
		case (state)
			tmu_pkg::idle: if (start) state_next = tmu_pkg::wait_process;
			tmu_pkg::wait_process: begin
				// last pixel taken and nothing left in decay or the write stage
				if (!run_q && !decay_busy_i && !burst_busy_i)
					state_next = tmu_pkg::flush;
			end
			tmu_pkg::flush: begin
				flush_o = 1'b1;
				state_next = tmu_pkg::wait_flush;
			end
			tmu_pkg::wait_flush: if (!burst_busy_i) state_next = tmu_pkg::idle;
			default: state_next = tmu_pkg::idle;
		endcase
	end

	a_flush_single: assert property (@(posedge sys_clk) disable iff (sys_rst)
		flush_o |=> !flush_o);

	a_irq_on_done: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq_o |-> (state == tmu_pkg::idle && $past(state) == tmu_pkg::wait_flush));

endmodule

// ==== source/tmu_decay.sv ====
// --------------------------------------
// brightness scaling and chroma-key stage
// --------------------------------------
`timescale 1ns/1ps

module tmu_decay #(
	parameter int fml_depth = 26
) (
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic run_i,
	input  logic [tmu_pkg::brightness_width-1:0] brightness_i,
	input  logic chroma_key_en_i,
	input  logic [tmu_pkg::color_width-1:0] chroma_key_i,

	input  logic pipe_stb_i,
	output logic pipe_ack_o,
	input  logic [tmu_pkg::color_width-1:0] color_i,
	input  logic [fml_depth-2:0] dadr_i,
	input  logic last_i,

	output logic pipe_stb_o,
	input  logic pipe_ack_i,
	output logic [tmu_pkg::color_width-1:0] color_o,
	output logic [fml_depth-2:0] dadr_o,
	output logic keep_o,

	output logic last_seen_o,
	output logic busy_o
);

	// channel * (brightness + 1) / 64, truncated
	function automatic logic [tmu_pkg::green_width-1:0] scale_channel(
		input logic [tmu_pkg::green_width-1:0] chan,
		input logic [tmu_pkg::brightness_width:0] factor
	);
		logic [tmu_pkg::green_width+tmu_pkg::brightness_width:0] product;
		product = chan * factor;
		return product[tmu_pkg::brightness_width +: tmu_pkg::green_width];
	endfunction

	logic [tmu_pkg::brightness_width:0] factor;
	logic [tmu_pkg::green_width-1:0] r_full, g_full, b_full;
	logic [tmu_pkg::color_width-1:0] scaled;
	logic accept;

	assign factor = {1'b0, brightness_i} + 1'b1;

	assign r_full = scale_channel({1'b0, color_i[tmu_pkg::color_width-1 -: tmu_pkg::red_width]}, factor);
	assign g_full = scale_channel(color_i[tmu_pkg::blue_width +: tmu_pkg::green_width], factor);
	assign b_full = scale_channel({1'b0, color_i[tmu_pkg::blue_width-1:0]}, factor);
	assign scaled = {r_full[tmu_pkg::red_width-1:0], g_full, b_full[tmu_pkg::blue_width-1:0]};

	assign pipe_ack_o = run_i && (!pipe_stb_o || pipe_ack_i);
	assign accept = pipe_stb_i && pipe_ack_o;
	assign last_seen_o = accept && last_i;
	assign busy_o = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (accept)
			pipe_stb_o <= 1'b1;
		else if (pipe_ack_i)
			pipe_stb_o <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			color_o <= scaled;
			dadr_o <= dadr_i;
			keep_o <= !(chroma_key_en_i && color_i == chroma_key_i); // key compare uses the raw color
		end
	end

	a_out_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o && !pipe_ack_i |=> pipe_stb_o && $stable({color_o, dadr_o, keep_o}));

endmodule

// ==== source/tmu_pixel.sv ====
// --------------------------------------
// pixel back end: control, decay, burst
// --------------------------------------
`timescale 1ns/1ps

module tmu_pixel #(
	parameter int fml_depth = 26,
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic [13:0] csr_a_i,
	input  logic csr_we_i,
	input  logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,

	output logic irq_o,

	input  logic pipe_stb_i,
	output logic pipe_ack_o,
	input  logic [tmu_pkg::color_width-1:0] color_i,
	input  logic [fml_depth-2:0] dadr_i,
	input  logic last_i,

	output logic [fml_depth-1:0] fmlw_adr_o,
	output logic fmlw_stb_o,
	output logic [tmu_pkg::fml_sel_width-1:0] fmlw_sel_o,
	output logic [tmu_pkg::fml_word_width-1:0] fmlw_do_o,
	input  logic fmlw_ack_i
);

	logic run;
	logic [tmu_pkg::brightness_width-1:0] brightness;
	logic chroma_key_en;
	logic [tmu_pkg::color_width-1:0] chroma_key;
	logic flush;
	logic last_seen;
	logic decay_busy;
	logic burst_busy;

	// decay to burst handshake
	logic decay_stb;
	logic decay_ack;
	logic [tmu_pkg::color_width-1:0] decay_color;
	logic [fml_depth-2:0] decay_dadr;
	logic decay_keep;

	tmu_ctlif #(
		.csr_addr(csr_addr)
	) tmu_ctlif_i (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a_i(csr_a_i),
		.csr_we_i(csr_we_i),
		.csr_di_i(csr_di_i),
		.csr_do_o(csr_do_o),
		.irq_o(irq_o),
		.run_o(run),
		.brightness_o(brightness),
		.chroma_key_en_o(chroma_key_en),
		.chroma_key_o(chroma_key),
		.flush_o(flush),
		.last_seen_i(last_seen),
		.decay_busy_i(decay_busy),
		.burst_busy_i(burst_busy)
	);

	tmu_decay #(
		.fml_depth(fml_depth)
	) tmu_decay_i (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.run_i(run),
		.brightness_i(brightness),
		.chroma_key_en_i(chroma_key_en),
		.chroma_key_i(chroma_key),
		.pipe_stb_i(pipe_stb_i),
		.pipe_ack_o(pipe_ack_o),
		.color_i(color_i),
		.dadr_i(dadr_i),
		.last_i(last_i),
		.pipe_stb_o(decay_stb),
		.pipe_ack_i(decay_ack),
		.color_o(decay_color),
		.dadr_o(decay_dadr),
		.keep_o(decay_keep),
		.last_seen_o(last_seen),
		.busy_o(decay_busy)
	);

	tmu_burst #(
		.fml_depth(fml_depth)
	) tmu_burst_i (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.flush_i(flush),
		.busy_o(burst_busy),
		.pipe_stb_i(decay_stb),
		.pipe_ack_o(decay_ack),
		.color_i(decay_color),
		.dadr_i(decay_dadr),
		.keep_i(decay_keep),
		.fmlw_adr_o(fmlw_adr_o),
		.fmlw_stb_o(fmlw_stb_o),
		.fmlw_sel_o(fmlw_sel_o),
		.fmlw_do_o(fmlw_do_o),
		.fmlw_ack_i(fmlw_ack_i)
	);

endmodule

// ==== tmu_pixel.f ====
common/tmu_pkg.sv
source/tmu_ctlif.sv
source/tmu_decay.sv
burst/tmu_burst.sv
source/tmu_pixel.sv
sim/fml_write_model.sv
sim/tmu_pixel_tb.sv
